// File: source/capture_types_pkg.sv
package capture_types_pkg;

   // field widths
   localparam int SAMPLE_W = 12;   // ADC resolution
   localparam int OFFSET_W = 16;
   localparam int COUNT_W  = 16;
   localparam int DECIM_W  = 8;

   // one ADC conversion result
   typedef logic [SAMPLE_W-1:0] adc_sample_t;

   // samples between the trigger and the first captured sample
   typedef logic [OFFSET_W-1:0] trig_offset_t;

   // kept samples in one capture
   typedef logic [COUNT_W-1:0]  sample_count_t;

   // decimation factor minus one, 0 keeps every sample
   typedef logic [DECIM_W-1:0]  decim_t;

   // trigger FSM states
   typedef enum logic [2:0] {
      IDLE,           // waiting for an arm command
      WAIT_INACTIVE,  // trigger must go inactive first
      ARMED,          // looking for the trigger condition
      OFFSET,         // counting down the trigger offset
      CAPTURE         // samples are marked active
   } trig_state_t;

   // where the trigger condition comes from
   typedef enum logic {
      EXT_PIN,
      ADC_LEVEL
   } trig_src_t;

endpackage

// File: source/capture_flow_pkg.sv
package capture_flow_pkg;

   // output buffer size in samples
   localparam int BUF_DEPTH = 16;
   localparam int BUF_AW    = $clog2(BUF_DEPTH);

   // entries the reader can take right after reset
   localparam int CREDIT_INIT = 4;
   localparam int CREDIT_W    = $clog2(CREDIT_INIT + 1);

   // extra msb tells full from empty
   typedef logic [BUF_AW:0] buf_ptr_t;

   // credits held towards the reader
   typedef logic [CREDIT_W-1:0] credit_t;

endpackage

// File: source/adc_sample_source.sv
`timescale 1ns/1ns

module adc_sample_source (
   input  logic                           ADC_clk_sample,
   input  logic                           reset,
   input  capture_types_pkg::adc_sample_t adc_data_i,      // ADC pins
   input  logic                           test_pattern_i,  // 1 selects the counter
   output capture_types_pkg::adc_sample_t smp_data_o
);
   import capture_types_pkg::*;

   adc_sample_t test_cnt_q;

   // free-running ramp, wraps at 4096
   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         test_cnt_q <= '0;
      end else begin
         test_cnt_q <= test_cnt_q + adc_sample_t'(1);
      end
   end

   // stage one sample register, one new sample every clock
   always_ff @(posedge ADC_clk_sample) begin
      if (test_pattern_i) begin
         smp_data_o <= test_cnt_q;
      end else begin
         smp_data_o <= adc_data_i;
      end
   end

endmodule

// File: source/trigger_unit.sv
`timescale 1ns/1ns

module trigger_unit (
   input  logic                            ADC_clk_sample,
   input  logic                            reset,
   input  capture_types_pkg::adc_sample_t  smp_data_i,
   input  logic                            arm_i,           // one-cycle command
   input  capture_types_pkg::trig_src_t    trig_src_i,
   input  logic                            trig_high_i,     // 1 = active high / at or above
   input  logic                            trig_wait_i,
   input  capture_types_pkg::adc_sample_t  trig_level_i,
   input  logic                            ext_trigger_i,
   input  capture_types_pkg::trig_offset_t trig_offset_i,
   input  logic                            capture_done_i,  // from the decimator
   output capture_types_pkg::adc_sample_t  smp_data_o,
   output logic                            capture_active_o,
   output logic                            armed_o
);
   import capture_types_pkg::*;

   trig_state_t  state_q;
   trig_state_t  state_d;
   trig_offset_t offset_cnt_q;
   trig_offset_t offset_cnt_d;
   logic         level_hit;
   logic         pin_hit;
   logic         trig_cond;
   logic         active_d;

   // polarity applies to both sources
   assign level_hit = trig_high_i ? (smp_data_i >= trig_level_i) : (smp_data_i <= trig_level_i);
   assign pin_hit   = trig_high_i ? ext_trigger_i : ~ext_trigger_i;
   assign trig_cond = (trig_src_i == ADC_LEVEL) ? level_hit : pin_hit;

   always_comb begin
      state_d      = state_q;
      offset_cnt_d = offset_cnt_q;
      active_d     = 1'b0;
      case (state_q)
         IDLE: begin
            if (arm_i) begin
               state_d = trig_wait_i ? WAIT_INACTIVE : ARMED;
            end
         end
         WAIT_INACTIVE: begin
            if (!trig_cond) begin
               state_d = ARMED;
            end
         end
         ARMED: begin
            if (trig_cond) begin
               if (trig_offset_i == '0) begin
                  active_d = 1'b1;  // triggering sample is the first one captured
                  state_d  = CAPTURE;
               end else begin
                  offset_cnt_d = trig_offset_i - trig_offset_t'(1);
                  state_d      = OFFSET;
               end
            end
         end
         OFFSET: begin
            // one sample per clock, so counting cycles counts samples
            if (offset_cnt_q == '0) begin
               active_d = 1'b1;
               state_d  = CAPTURE;
            end else begin
               offset_cnt_d = offset_cnt_q - trig_offset_t'(1);
            end
         end
         CAPTURE: begin
            if (capture_done_i) begin
               state_d = IDLE;
            end else begin
               active_d = 1'b1;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state_q          <= IDLE;
         offset_cnt_q     <= '0;
         capture_active_o <= 1'b0;
      end else begin
         state_q          <= state_d;
         offset_cnt_q     <= offset_cnt_d;
         capture_active_o <= active_d;  // travels with the sample below
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      smp_data_o <= smp_data_i;
   end

   assign armed_o = (state_q == WAIT_INACTIVE) || (state_q == ARMED);

endmodule

// File: source/sample_decimator.sv
`timescale 1ns/1ns

module sample_decimator (
   input  logic                             ADC_clk_sample,
   input  logic                             reset,
   input  capture_types_pkg::adc_sample_t   smp_data_i,
   input  logic                             capture_active_i,
   input  capture_types_pkg::decim_t        decim_i,
   input  capture_types_pkg::sample_count_t max_samples_i,
   output logic                             kept_valid_o,
   output capture_types_pkg::adc_sample_t   kept_data_o,
   output logic                             capture_done_o   // with the last kept sample
);
   import capture_types_pkg::*;

   logic          active_q;
   logic          start;
   logic          done_q;
   logic          keep;
   logic          last;
   decim_t        phase_q;
   sample_count_t kept_cnt_q;
   sample_count_t cnt_next;

   assign start = capture_active_i & ~active_q;  // rising edge of the capture window

   // first active sample always kept, later ones when the phase wraps
   assign keep     = capture_active_i & (start | (~done_q & (phase_q == '0)));
   assign cnt_next = (start ? '0 : kept_cnt_q) + sample_count_t'(1);
   assign last     = keep & (cnt_next == max_samples_i);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         active_q       <= 1'b0;
         done_q         <= 1'b0;
         phase_q        <= '0;
         kept_cnt_q     <= '0;
         kept_valid_o   <= 1'b0;
         capture_done_o <= 1'b0;
      end else begin
         active_q       <= capture_active_i;
         kept_valid_o   <= keep;
         capture_done_o <= last;
         // blocks the samples still in flight after the stop point
         done_q         <= (done_q & ~start) | last;
         if (keep) begin
            kept_cnt_q <= cnt_next;
         end
         if (capture_active_i) begin
            if (start || (phase_q == '0)) begin
               phase_q <= decim_i;
            end else begin
               phase_q <= phase_q - decim_t'(1);
            end
         end
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      kept_data_o <= smp_data_i;
   end

endmodule

// File: source/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
   input  logic                           ADC_clk_sample,
   input  logic                           reset,
   input  logic                           kept_valid_i,
   input  capture_types_pkg::adc_sample_t kept_data_i,
   input  logic                           credit_return_i,   // one pulse per freed entry
   input  logic                           clear_overflow_i,
   output logic                           sample_valid_o,
   output capture_types_pkg::adc_sample_t sample_data_o,
   output logic                           overflow_o
);
   import capture_types_pkg::*;
   import capture_flow_pkg::*;

   adc_sample_t mem [BUF_DEPTH];
   buf_ptr_t    wr_ptr_q;
   buf_ptr_t    rd_ptr_q;
   credit_t     credit_q;
   logic        empty;
   logic        full;
   logic        has_credit;
   logic        pop;
   logic        bypass;
   logic        push;
   logic        drop;
   logic        send;

   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full  = (wr_ptr_q[BUF_AW] != rd_ptr_q[BUF_AW]) &&
                  (wr_ptr_q[BUF_AW-1:0] == rd_ptr_q[BUF_AW-1:0]);

   assign has_credit = (credit_q != '0);
   assign pop        = has_credit & ~empty;
   // empty buffer with a credit in hand, sample goes straight to the output
   assign bypass     = has_credit & empty & kept_valid_i;
   // a full buffer still accepts while the head leaves in the same cycle
   assign push       = kept_valid_i & ~bypass & (~full | pop);
   assign drop       = kept_valid_i & ~bypass & full & ~pop;
   assign send       = pop | bypass;

   always_ff @(posedge ADC_clk_sample) begin
      if (push) begin
         mem[wr_ptr_q[BUF_AW-1:0]] <= kept_data_i;
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         wr_ptr_q       <= '0;
         rd_ptr_q       <= '0;
         credit_q       <= credit_t'(CREDIT_INIT);
         sample_valid_o <= 1'b0;
         overflow_o     <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + buf_ptr_t'(1);
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + buf_ptr_t'(1);
         end
         // spend and return in one cycle cancel
         case ({send, credit_return_i})
            2'b10:   credit_q <= credit_q - credit_t'(1);
            2'b01:   credit_q <= credit_q + credit_t'(1);
            default: credit_q <= credit_q;
         endcase
         sample_valid_o <= send;
         if (clear_overflow_i) begin
            overflow_o <= 1'b0;
         end else if (drop) begin
            overflow_o <= 1'b1;  // sticky until the next arm
         end
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (bypass) begin
         sample_data_o <= kept_data_i;
      end else if (pop) begin
         sample_data_o <= mem[rd_ptr_q[BUF_AW-1:0]];
      end
   end

endmodule

// File: source/adc_capture_top.sv
`timescale 1ns/1ns

module adc_capture_top (
   input  logic                             ADC_clk_sample,
   input  logic                             reset,
   input  capture_types_pkg::adc_sample_t   adc_data_i,
   input  logic                             test_pattern_i,
   input  logic                             arm_i,
   input  capture_types_pkg::trig_src_t     trig_src_i,
   input  logic                             trig_high_i,
   input  logic                             trig_wait_i,
   input  capture_types_pkg::adc_sample_t   trig_level_i,
   input  logic                             ext_trigger_i,
   input  capture_types_pkg::trig_offset_t  trig_offset_i,
   input  capture_types_pkg::decim_t        decim_i,
   input  capture_types_pkg::sample_count_t max_samples_i,
   input  logic                             credit_return_i,
   output logic                             sample_valid_o,
   output capture_types_pkg::adc_sample_t   sample_data_o,
   output logic                             armed_o,
   output logic                             capturing_o,
   output logic                             overflow_o,
   output logic                             led_armed_o,
   output logic                             led_capture_o
);
   import capture_types_pkg::*;

   adc_sample_t smp_data;        // stage one
   adc_sample_t trig_smp_data;   // stage two, aligned with capture_active
   logic        capture_active;
   logic        kept_valid;
   adc_sample_t kept_data;
   logic        capture_done;

   adc_sample_source adc_sample_source_i (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .test_pattern_i (test_pattern_i),
      .smp_data_o     (smp_data)
   );

   trigger_unit trigger_unit_i (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .smp_data_i       (smp_data),
      .arm_i            (arm_i),
      .trig_src_i       (trig_src_i),
      .trig_high_i      (trig_high_i),
      .trig_wait_i      (trig_wait_i),
      .trig_level_i     (trig_level_i),
      .ext_trigger_i    (ext_trigger_i),
      .trig_offset_i    (trig_offset_i),
      .capture_done_i   (capture_done),
      .smp_data_o       (trig_smp_data),
      .capture_active_o (capture_active),
      .armed_o          (armed_o)
   );

   sample_decimator sample_decimator_i (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .smp_data_i       (trig_smp_data),
      .capture_active_i (capture_active),
      .decim_i          (decim_i),
      .max_samples_i    (max_samples_i),
      .kept_valid_o     (kept_valid),
      .kept_data_o      (kept_data),
      .capture_done_o   (capture_done)
   );

   // the arm command also clears a previous overflow
   sample_fifo sample_fifo_i (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .kept_valid_i     (kept_valid),
      .kept_data_i      (kept_data),
      .credit_return_i  (credit_return_i),
      .clear_overflow_i (arm_i),
      .sample_valid_o   (sample_valid_o),
      .sample_data_o    (sample_data_o),
      .overflow_o       (overflow_o)
   );

   assign capturing_o   = capture_active;
   assign led_armed_o   = armed_o;
   assign led_capture_o = capture_active;  // lit only while samples are taken

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o   = 1'b0;
      reset_o = 1'b1;
      repeat (16) @(posedge clk_o);
      #1 reset_o = 1'b0;  // released just after an edge, like the other inputs
   end

   always #4 clk_o = ~clk_o;  // 8 ns period

endmodule

// File: bench/adc_capture_props.sv
`timescale 1ns/1ns

module adc_capture_props (
   input logic ADC_clk_sample,
   input logic reset,
   input logic arm_i,
   input logic credit_return_i,
   input logic sample_valid_o,
   input logic armed_o,
   input logic capturing_o,
   input logic overflow_o
);
   import capture_flow_pkg::*;

   int outstanding_q;  // words sent minus credits returned
   int fail_cnt = 0;   // failed assertions, collected at the end of the run

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         outstanding_q <= 0;
      end else begin
         outstanding_q <= outstanding_q + int'(sample_valid_o) - int'(credit_return_i);
      end
   end

   a_credit_bound: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      outstanding_q <= CREDIT_INIT && outstanding_q >= 0)
      else begin
         $error("outstanding words out of credit range");
         fail_cnt = fail_cnt + 1;
      end

   a_valid_needs_credit: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      sample_valid_o |-> outstanding_q < CREDIT_INIT)
      else begin
         $error("word sent without a credit");
         fail_cnt = fail_cnt + 1;
      end

   a_overflow_sticky: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      (overflow_o && !arm_i) |=> overflow_o)
      else begin
         $error("overflow flag dropped without an arm");
         fail_cnt = fail_cnt + 1;
      end

   a_armed_after_arm: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      $rose(armed_o) |-> $past(arm_i))
      else begin
         $error("armed without an arm command");
         fail_cnt = fail_cnt + 1;
      end

   // reset leaves the status outputs low
   a_reset_low: assert property (@(posedge ADC_clk_sample)
      reset |=> (!sample_valid_o && !armed_o && !capturing_o && !overflow_o))
      else begin
         $error("output high right after reset");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind adc_capture_top adc_capture_props adc_capture_props_i (.*);

// File: bench/adc_capture_tb.sv
`timescale 1ns/1ns

module adc_capture_tb;
   import capture_types_pkg::*;
   import capture_flow_pkg::*;

   localparam int CLK_PERIOD  = 8;
   localparam int TEST_CYCLES = 1500;  // rough sum of all test lengths

   logic          clk;
   logic          reset;
   adc_sample_t   adc_data;
   logic          test_pattern;
   logic          arm;
   trig_src_t     trig_src;
   logic          trig_high;
   logic          trig_wait;
   adc_sample_t   trig_level;
   logic          ext_trigger;
   trig_offset_t  trig_offset;
   decim_t        decim;
   sample_count_t max_samples;
   logic          credit_return;
   logic          sample_valid;
   adc_sample_t   sample_data;
   logic          armed;
   logic          capturing;
   logic          overflow;
   logic          led_armed;
   logic          led_capture;

   adc_sample_t   words[$];      // everything the reader has received
   int            owed;          // credits the reader still has to return
   int            delay_cnt;
   logic          hold_credits;
   logic          ramp_en;
   integer        seed;
   int            errors;
   int            checks;
   int            prop_fails;    // failures of the bound assertions

   tb_clock_gen tb_clock_gen_i (
      .clk_o   (clk),
      .reset_o (reset)
   );

   adc_capture_top adc_capture_top_i (
      .ADC_clk_sample  (clk),
      .reset           (reset),
      .adc_data_i      (adc_data),
      .test_pattern_i  (test_pattern),
      .arm_i           (arm),
      .trig_src_i      (trig_src),
      .trig_high_i     (trig_high),
      .trig_wait_i     (trig_wait),
      .trig_level_i    (trig_level),
      .ext_trigger_i   (ext_trigger),
      .trig_offset_i   (trig_offset),
      .decim_i         (decim),
      .max_samples_i   (max_samples),
      .credit_return_i (credit_return),
      .sample_valid_o  (sample_valid),
      .sample_data_o   (sample_data),
      .armed_o         (armed),
      .capturing_o     (capturing),
      .overflow_o      (overflow),
      .led_armed_o     (led_armed),
      .led_capture_o   (led_capture)
   );

   // reader model, takes each word as it arrives
   always @(posedge clk) begin
      if (!reset && sample_valid) begin
         words.push_back(sample_data);
         owed = owed + 1;
      end
   end

   // hands credits back one per pulse after a random pause
   always @(posedge clk) begin
      #1;
      credit_return = 1'b0;
      if (!reset && !hold_credits && owed > 0) begin
         if (delay_cnt == 0) begin
            credit_return = 1'b1;
            owed          = owed - 1;
            delay_cnt     = $random(seed) & 3;
         end else begin
            delay_cnt = delay_cnt - 1;
         end
      end
   end

   // rising ramp on the ADC pins, one step per sample
   always @(posedge clk) begin
      #1;
      if (ramp_en) begin
         adc_data = adc_data + 12'd1;
      end
   end

   task automatic check(input logic ok, input string msg);
      checks = checks + 1;
      assert (ok) else begin
         errors = errors + 1;
         $display("ERROR at %0t ns: %s", $time, msg);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic pulse_arm();
      @(posedge clk);
      #1 arm = 1'b1;
      @(posedge clk);
      #1 arm = 1'b0;
   endtask

   task automatic wait_capture_end();
      int n;
      n = 0;
      while (!capturing && n < 200) begin
         wait_cycles(1);
         n = n + 1;
      end
      if (!capturing) begin
         errors = errors + 1;
         $display("capture never started after the trigger");
      end else begin
         check(led_capture, "capture LED dark while capturing");
      end
      n = 0;
      while (capturing && n < 500) begin
         wait_cycles(1);
         n = n + 1;
      end
      if (capturing) begin
         errors = errors + 1;
         $display("capture did not stop after the programmed sample count");
      end
      check(!led_capture, "capture LED still lit after the capture");
   endtask

   task automatic wait_words(input int n);
      int c;
      c = 0;
      while (words.size() < n && c < 400) begin
         wait_cycles(1);
         c = c + 1;
      end
      wait_cycles(20);  // lets any surplus word show up
      check(words.size() == n, $sformatf("expected %0d words, got %0d", n, words.size()));
   endtask

   task automatic run_pattern(input int d, input int m);
      adc_sample_t diff;
      test_pattern = 1'b1;
      trig_src     = EXT_PIN;
      trig_high    = 1'b1;
      trig_wait    = 1'b0;
      ext_trigger  = 1'b1;
      trig_offset  = '0;
      decim        = decim_t'(d);
      max_samples  = sample_count_t'(m);
      words.delete();
      pulse_arm();
      wait_capture_end();
      wait_words(m);
      check(!capturing, "capturing_o still high after the capture");
      check(!armed && !led_armed, "still armed after the capture");
      for (int i = 1; i < words.size(); i++) begin
         diff = words[i] - words[i-1];
         check(diff == adc_sample_t'(d + 1),
               $sformatf("word %0d steps by %0d, decimation %0d", i, diff, d));
      end
   endtask

   initial begin
      seed          = 32'hfc57dad1;
      errors        = 0;
      checks        = 0;
      prop_fails    = 0;
      owed          = 0;
      delay_cnt     = 0;
      hold_credits  = 1'b0;
      ramp_en       = 1'b0;
      adc_data      = '0;
      test_pattern  = 1'b1;
      arm           = 1'b0;
      trig_src      = EXT_PIN;
      trig_high     = 1'b1;
      trig_wait     = 1'b0;
      trig_level    = '0;
      ext_trigger   = 1'b1;  // trigger present, but nothing is armed yet
      trig_offset   = '0;
      decim         = '0;
      max_samples   = 16'd10;
      credit_return = 1'b0;

      wait (!reset);
      wait_cycles(50);
      check(words.size() == 0, "words came out before any arm");

      run_pattern(0, 10);
      run_pattern(3, 12);

      // level trigger on a ramp
      test_pattern = 1'b0;
      trig_src     = ADC_LEVEL;
      trig_level   = 12'd100;
      trig_offset  = 16'd5;
      decim        = '0;
      max_samples  = 16'd8;
      adc_data     = '0;
      words.delete();
      pulse_arm();
      ramp_en = 1'b1;
      wait_capture_end();
      ramp_en = 1'b0;
      wait_words(8);
      if (words.size() > 0) begin
         check(words[0] == 12'd105, $sformatf("first ramp word %0d, expected 105", words[0]));
      end

      // trigger wait with the pin already active
      test_pattern = 1'b1;
      trig_src     = EXT_PIN;
      trig_wait    = 1'b1;
      trig_offset  = '0;
      ext_trigger  = 1'b1;
      max_samples  = 16'd6;
      words.delete();
      pulse_arm();
      wait_cycles(30);
      check(armed && !capturing, "capture started while the pin never went inactive");
      check(led_armed && !led_capture, "LEDs do not show the armed state");
      check(words.size() == 0, "words came out before the pin toggled");
      ext_trigger = 1'b0;
      wait_cycles(5);
      ext_trigger = 1'b1;
      wait_capture_end();
      wait_words(6);
      trig_wait = 1'b0;

      // overflow with credits withheld
      hold_credits = 1'b1;
      max_samples  = sample_count_t'(BUF_DEPTH + CREDIT_INIT + 10);
      words.delete();
      pulse_arm();
      wait_capture_end();
      wait_cycles(5);
      check(overflow, "overflow_o did not set on a full buffer");
      wait_cycles(20);
      check(overflow, "overflow_o cleared without an arm");
      check(words.size() == CREDIT_INIT, "words sent beyond the initial credits");
      hold_credits = 1'b0;
      wait_words(BUF_DEPTH + CREDIT_INIT);
      ext_trigger = 1'b0;  // arm again without a trigger to clear the flag
      pulse_arm();
      wait_cycles(1);
      check(!overflow, "overflow_o not cleared by arm");

      wait_cycles(10);
      prop_fails = adc_capture_top_i.adc_capture_props_i.fail_cnt;
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, prop_fails);
      if (errors == 0 && prop_fails == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD + 1000);
      $display("watchdog expired before the tests completed");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: filelist.f
source/capture_types_pkg.sv
source/capture_flow_pkg.sv
source/adc_sample_source.sv
source/trigger_unit.sv
source/sample_decimator.sv
source/sample_fifo.sv
source/adc_capture_top.sv
bench/tb_clock_gen.sv
bench/adc_capture_props.sv
bench/adc_capture_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= adc_capture_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
